// ==== Makefile ====
# Verilator flow for the register-read stage testbench.

VERILATOR ?= verilator
TOP       := regReadStage_tb
FILELIST  := regReadStage.f
FLAGS     := --assert --timing --top-module $(TOP)
OBJ_DIR   := obj_dir
LOG       := sim.log
SIM_ARGS  := +verilator+error+limit+1000
FAIL_MSG  := ERRORS FOUND
PASS_MSG  := NO ERRORS

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(FLAGS) --Mdir $(OBJ_DIR) -o V$(TOP) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	else \
	  echo "Simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== regReadStage.f ====
rtl/rrConfigPkg.sv
rtl/rrTypesPkg.sv
rtl/regReadIf.sv
rtl/physRegFile.sv
rtl/operandLane.sv
rtl/readyScoreboard.sv
rtl/regReadStage.sv
test/regReadStage_chk.sv
test/regReadStage_tb.sv

// ==== rtl/operandLane.sv ====
// **************************************************
// One issue lane with operand read, bypass select, squash
// and the output register of the stage.
// **************************************************

`timescale 1ns/1ps
`default_nettype none

module operandLane (
  input  logic clk,
  input  logic rst_i,
  input  logic issueValid_i,
  input  rrTypesPkg::physTag_t src1Tag_i,
  input  rrTypesPkg::physTag_t src2Tag_i,
  input  rrTypesPkg::branchMask_t branchMask_i,
  input  rrTypesPkg::alId_t alId_i,
  regReadIf.lane readPort,
  input  logic [rrConfigPkg::NUM_LANES-1:0] bypassValid_i,
  input  rrTypesPkg::physTag_t [rrConfigPkg::NUM_LANES-1:0] bypassDest_i,
  input  rrTypesPkg::regData_t [rrConfigPkg::NUM_LANES-1:0] bypassData_i,
  input  logic mispredict_i,
  input  rrTypesPkg::ckptId_t mispredictCkpt_i,
  output logic laneValid_o,
  output rrTypesPkg::regData_t src1Data_o,
  output rrTypesPkg::regData_t src2Data_o,
  output rrTypesPkg::alId_t alId_o
);

  import rrConfigPkg::*;
  import rrTypesPkg::*;

  regData_t src1Operand;
  regData_t src2Operand;
  logic squash;

  // Scanning from the top port down leaves the lowest matching port in place.
  function automatic regData_t pickOperand(input physTag_t tag, input regData_t fileData);
    regData_t result;
    result = fileData;
    for (int p = NUM_LANES - 1; p >= 0; p--) begin
      if (bypassValid_i[p] && (bypassDest_i[p] == tag)) begin
        result = bypassData_i[p];
      end
    end
    return result;
  endfunction

  assign readPort.src1Tag = src1Tag_i;
  assign readPort.src2Tag = src2Tag_i;

  // Bypass wins over the file even while writes are held off by recovery.
  always_comb begin
    src1Operand = pickOperand(src1Tag_i, readPort.src1Data);
    src2Operand = pickOperand(src2Tag_i, readPort.src2Data);
  end

  assign squash = mispredict_i && branchMask_i[mispredictCkpt_i];  // Lane depends on bad branch.

  always_ff @(posedge clk) begin
    if (rst_i) begin
      laneValid_o <= 1'b0;
    end else begin
      laneValid_o <= issueValid_i && !squash;
    end
  end

  // Payload moves every cycle whether or not the lane is valid.
  always_ff @(posedge clk) begin
    src1Data_o <= src1Operand;
    src2Data_o <= src2Operand;
    alId_o <= alId_i;
  end

endmodule

`default_nettype wire

// ==== rtl/physRegFile.sv ====
// **************************************************
// Physical register file with eight async reads and four writes.
// Writes land on the clock edge, reads see the old contents.
// **************************************************

`timescale 1ns/1ps
`default_nettype none

module physRegFile (
  input  logic clk,
  input  logic rst_i,
  input  logic [rrConfigPkg::NUM_LANES-1:0] writeEn_i,
  input  rrTypesPkg::physTag_t [rrConfigPkg::NUM_LANES-1:0] writeTag_i,
  input  rrTypesPkg::regData_t [rrConfigPkg::NUM_LANES-1:0] writeData_i,
  regReadIf.file readPorts [rrConfigPkg::NUM_LANES]
);

  import rrConfigPkg::*;
  import rrTypesPkg::*;

  regData_t regs [NUM_PHYS_REGS];

  // Ports are applied in order, so the last write to a tag is the one kept.
  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int r = 0; r < NUM_PHYS_REGS; r++) begin
        regs[r] <= '0;
      end
    end else begin
      for (int w = 0; w < NUM_LANES; w++) begin
        if (writeEn_i[w]) begin
          regs[writeTag_i[w]] <= writeData_i[w];
        end
      end
    end
  end

  // Two read ports per lane.
  for (genvar g = 0; g < NUM_LANES; g++) begin : genRead
    assign readPorts[g].src1Data = regs[readPorts[g].src1Tag];
    assign readPorts[g].src2Data = regs[readPorts[g].src2Tag];
  end

endmodule

`default_nettype wire

// ==== rtl/readyScoreboard.sv ====
// **************************************************
// Ready bit per physical register, cleared on unmap and
// set again on wakeup.
// **************************************************

`timescale 1ns/1ps
`default_nettype none

module readyScoreboard (
  input  logic clk,
  input  logic rst_i,
  input  logic exception_i,
  input  logic [rrConfigPkg::NUM_LANES-1:0] unmapValid_i,
  input  rrTypesPkg::physTag_t [rrConfigPkg::NUM_LANES-1:0] unmapTag_i,
  input  logic [rrConfigPkg::NUM_LANES-1:0] wakeupValid_i,
  input  rrTypesPkg::physTag_t [rrConfigPkg::NUM_LANES-1:0] wakeupTag_i,
  output rrTypesPkg::readyVec_t phyRegRdy_o
);

  import rrConfigPkg::*;
  import rrTypesPkg::*;

  readyVec_t readyNext;

  // Wakeups are applied after unmaps so a set beats a clear on the same tag.
  always_comb begin
    readyNext = phyRegRdy_o;
    for (int u = 0; u < NUM_LANES; u++) begin
      if (unmapValid_i[u]) begin
        readyNext[unmapTag_i[u]] = 1'b0;
      end
    end
    for (int k = 0; k < NUM_LANES; k++) begin
      if (wakeupValid_i[k]) begin
        readyNext[wakeupTag_i[k]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i || exception_i) begin
      // Only the architectural mappings hold committed values.
      phyRegRdy_o <= {{(NUM_PHYS_REGS - NUM_ARCH_REGS){1'b0}}, {NUM_ARCH_REGS{1'b1}}};
    end else begin
      phyRegRdy_o <= readyNext;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/regReadIf.sv ====
// **************************************************
// One lane's read request to the register file.
// **************************************************

`timescale 1ns/1ps
`default_nettype none

interface regReadIf;

  import rrTypesPkg::*;

  physTag_t src1Tag;
  physTag_t src2Tag;
  regData_t src1Data;
  regData_t src2Data;

  // The lane presents tags and gets data back in the same cycle.
  modport lane (output src1Tag, output src2Tag, input src1Data, input src2Data);

  modport file (input src1Tag, input src2Tag, output src1Data, output src2Data);

endinterface

`default_nettype wire

// ==== rtl/regReadStage.sv ====
// **************************************************
// Register-read stage top with four lanes over a shared file.
// **************************************************

`timescale 1ns/1ps
`default_nettype none

module regReadStage (
  input  logic clk,
  input  logic rst_i,
  input  logic [rrConfigPkg::NUM_LANES-1:0] laneValid_i,
  input  rrTypesPkg::physTag_t [rrConfigPkg::NUM_LANES-1:0] src1Tag_i,
  input  rrTypesPkg::physTag_t [rrConfigPkg::NUM_LANES-1:0] src2Tag_i,
  input  rrTypesPkg::branchMask_t [rrConfigPkg::NUM_LANES-1:0] branchMask_i,
  input  rrTypesPkg::alId_t [rrConfigPkg::NUM_LANES-1:0] alId_i,
  input  logic [rrConfigPkg::NUM_LANES-1:0] bypassValid_i,
  input  rrTypesPkg::physTag_t [rrConfigPkg::NUM_LANES-1:0] bypassDest_i,
  input  rrTypesPkg::regData_t [rrConfigPkg::NUM_LANES-1:0] bypassData_i,
  input  logic [rrConfigPkg::NUM_LANES-1:0] unmapValid_i,
  input  rrTypesPkg::physTag_t [rrConfigPkg::NUM_LANES-1:0] unmapTag_i,
  input  logic [rrConfigPkg::NUM_LANES-1:0] wakeupValid_i,
  input  rrTypesPkg::physTag_t [rrConfigPkg::NUM_LANES-1:0] wakeupTag_i,
  input  logic ctrlVerified_i,
  input  logic ctrlMispredict_i,
  input  rrTypesPkg::ckptId_t ctrlCkptId_i,
  input  logic recover_i,
  input  logic exception_i,
  output logic [rrConfigPkg::NUM_LANES-1:0] laneValid_o,
  output rrTypesPkg::regData_t [rrConfigPkg::NUM_LANES-1:0] src1Data_o,
  output rrTypesPkg::regData_t [rrConfigPkg::NUM_LANES-1:0] src2Data_o,
  output rrTypesPkg::alId_t [rrConfigPkg::NUM_LANES-1:0] alId_o,
  output rrTypesPkg::readyVec_t phyRegRdy_o
);

  import rrConfigPkg::*;

  logic [NUM_LANES-1:0] writeEn;
  logic mispredict;

  regReadIf readIf [NUM_LANES] ();

  // Results on the bypass bus are not committed to the file during recovery.
  assign writeEn = bypassValid_i & ~{NUM_LANES{recover_i}};
  assign mispredict = ctrlVerified_i && ctrlMispredict_i;

  physRegFile regFile (
    .clk         (clk),
    .rst_i       (rst_i),
    .writeEn_i   (writeEn),
    .writeTag_i  (bypassDest_i),
    .writeData_i (bypassData_i),
    .readPorts   (readIf)
  );

  readyScoreboard scoreboard (
    .clk           (clk),
    .rst_i         (rst_i),
    .exception_i   (exception_i),
    .unmapValid_i  (unmapValid_i),
    .unmapTag_i    (unmapTag_i),
    .wakeupValid_i (wakeupValid_i),
    .wakeupTag_i   (wakeupTag_i),
    .phyRegRdy_o   (phyRegRdy_o)
  );

  for (genvar g = 0; g < NUM_LANES; g++) begin : genLane
    operandLane lane (
      .clk              (clk),
      .rst_i            (rst_i),
      .issueValid_i     (laneValid_i[g]),
      .src1Tag_i        (src1Tag_i[g]),
      .src2Tag_i        (src2Tag_i[g]),
      .branchMask_i     (branchMask_i[g]),
      .alId_i           (alId_i[g]),
      .readPort         (readIf[g]),
      .bypassValid_i    (bypassValid_i),
      .bypassDest_i     (bypassDest_i),
      .bypassData_i     (bypassData_i),
      .mispredict_i     (mispredict),
      .mispredictCkpt_i (ctrlCkptId_i),
      .laneValid_o      (laneValid_o[g]),
      .src1Data_o       (src1Data_o[g]),
      .src2Data_o       (src2Data_o[g]),
      .alId_o           (alId_o[g])
    );
  end

endmodule

`default_nettype wire

// ==== rtl/rrConfigPkg.sv ====
// **************************************************
// Sizes and counts shared by the register-read stage.
// **************************************************

`default_nettype none

package rrConfigPkg;

  // Issue lanes; the bypass network has one port per lane.
  localparam int NUM_LANES = 4;

  localparam int NUM_PHYS_REGS = 64;
  localparam int PHYS_TAG_W = 6;    // Enough to index every physical register.
  localparam int DATA_W = 32;

  // Branch checkpoints and the id that selects one of them.
  localparam int NUM_CHECKPOINTS = 4;
  localparam int CKPT_ID_W = 2;

  // Architectural registers are mapped and ready out of reset.
  localparam int NUM_ARCH_REGS = 32;

  localparam int AL_ID_W = 7;

endpackage

`default_nettype wire

// ==== rtl/rrTypesPkg.sv ====
// **************************************************
// Typed vectors for tags, data, masks and ids.
// **************************************************

`default_nettype none

package rrTypesPkg;

  import rrConfigPkg::*;

  typedef logic [PHYS_TAG_W-1:0] physTag_t;
  typedef logic [DATA_W-1:0] regData_t;

  // One bit per checkpoint the instruction sits behind.
  typedef logic [NUM_CHECKPOINTS-1:0] branchMask_t;
  typedef logic [CKPT_ID_W-1:0] ckptId_t;

  typedef logic [AL_ID_W-1:0] alId_t;
  typedef logic [NUM_PHYS_REGS-1:0] readyVec_t;   // Indexed by physical tag.

endpackage

`default_nettype wire

// ==== test/regReadStage_chk.sv ====
// **************************************************
// Checker bound into the stage top. It models the file and
// the ready vector from the inputs and compares by assertions.
// **************************************************

`timescale 1ns/1ps
`default_nettype none

module regReadStage_chk (
  input logic clk,
  input logic rst_i,
  input logic [rrConfigPkg::NUM_LANES-1:0] laneValid_i,
  input rrTypesPkg::physTag_t [rrConfigPkg::NUM_LANES-1:0] src1Tag_i,
  input rrTypesPkg::physTag_t [rrConfigPkg::NUM_LANES-1:0] src2Tag_i,
  input rrTypesPkg::branchMask_t [rrConfigPkg::NUM_LANES-1:0] branchMask_i,
  input rrTypesPkg::alId_t [rrConfigPkg::NUM_LANES-1:0] alId_i,
  input logic [rrConfigPkg::NUM_LANES-1:0] bypassValid_i,
  input rrTypesPkg::physTag_t [rrConfigPkg::NUM_LANES-1:0] bypassDest_i,
  input rrTypesPkg::regData_t [rrConfigPkg::NUM_LANES-1:0] bypassData_i,
  input logic [rrConfigPkg::NUM_LANES-1:0] unmapValid_i,
  input rrTypesPkg::physTag_t [rrConfigPkg::NUM_LANES-1:0] unmapTag_i,
  input logic [rrConfigPkg::NUM_LANES-1:0] wakeupValid_i,
  input rrTypesPkg::physTag_t [rrConfigPkg::NUM_LANES-1:0] wakeupTag_i,
  input logic ctrlVerified_i,
  input logic ctrlMispredict_i,
  input rrTypesPkg::ckptId_t ctrlCkptId_i,
  input logic recover_i,
  input logic exception_i,
  input logic [rrConfigPkg::NUM_LANES-1:0] laneValid_o,
  input rrTypesPkg::regData_t [rrConfigPkg::NUM_LANES-1:0] src1Data_o,
  input rrTypesPkg::regData_t [rrConfigPkg::NUM_LANES-1:0] src2Data_o,
  input rrTypesPkg::alId_t [rrConfigPkg::NUM_LANES-1:0] alId_o,
  input rrTypesPkg::readyVec_t phyRegRdy_o
);

  import rrConfigPkg::*;
  import rrTypesPkg::*;

  regData_t shadowRegs [NUM_PHYS_REGS];
  readyVec_t expReady;
  logic [NUM_LANES-1:0] expValid;
  regData_t [NUM_LANES-1:0] expSrc1;
  regData_t [NUM_LANES-1:0] expSrc2;
  alId_t [NUM_LANES-1:0] expAlId;
  logic started = 1'b0;
  logic dataOn = 1'b0;   // Payload is not reset, so compare only after reset ends.
  int errCount = 0;

  function automatic readyVec_t archReady();
    readyVec_t mask;
    mask = '0;
    for (int r = 0; r < NUM_ARCH_REGS; r++) begin
      mask[r] = 1'b1;
    end
    return mask;
  endfunction

  // The first valid bypass port with a matching dest supplies the operand.
  function automatic regData_t expectOperand(input physTag_t tag, input regData_t fileVal);
    for (int p = 0; p < NUM_LANES; p++) begin
      if (bypassValid_i[p] && bypassDest_i[p] == tag) begin
        return bypassData_i[p];
      end
    end
    return fileVal;
  endfunction

  function automatic readyVec_t nextReady(input readyVec_t current);
    readyVec_t clearMask;
    readyVec_t setMask;
    clearMask = '0;
    setMask = '0;
    for (int p = 0; p < NUM_LANES; p++) begin
      clearMask[unmapTag_i[p]] = clearMask[unmapTag_i[p]] | unmapValid_i[p];
      setMask[wakeupTag_i[p]] = setMask[wakeupTag_i[p]] | wakeupValid_i[p];
    end
    return (current & ~clearMask) | setMask;
  endfunction

  always @(posedge clk) begin : model
    readyVec_t written;
    written = '0;
    started <= 1'b1;
    dataOn <= !rst_i;
    for (int l = 0; l < NUM_LANES; l++) begin
      expValid[l] <= !rst_i && laneValid_i[l]
                     && !(ctrlVerified_i && ctrlMispredict_i && branchMask_i[l][ctrlCkptId_i]);
      expAlId[l] <= alId_i[l];
      expSrc1[l] <= expectOperand(src1Tag_i[l], shadowRegs[src1Tag_i[l]]);
      expSrc2[l] <= expectOperand(src2Tag_i[l], shadowRegs[src2Tag_i[l]]);
    end
    if (rst_i) begin
      for (int r = 0; r < NUM_PHYS_REGS; r++) begin
        shadowRegs[r] <= '0;
      end
    end else if (!recover_i) begin
      // The highest port claims a tag first; lower duplicates are dropped.
      for (int p = NUM_LANES - 1; p >= 0; p--) begin
        if (bypassValid_i[p] && !written[bypassDest_i[p]]) begin
          shadowRegs[bypassDest_i[p]] <= bypassData_i[p];
          written[bypassDest_i[p]] = 1'b1;
        end
      end
    end
    expReady <= (rst_i || exception_i) ? archReady() : nextReady(expReady);
  end

  aLaneValid: assert property (@(posedge clk) started |-> laneValid_o == expValid)
    else begin
      errCount++;
      $error("Mismatch laneValid_o: got %h expected %h", $sampled(laneValid_o),
             $sampled(expValid));
    end

  aAlId: assert property (@(posedge clk) started |-> alId_o == expAlId)
    else begin
      errCount++;
      $error("Mismatch alId_o: got %h expected %h", $sampled(alId_o), $sampled(expAlId));
    end

  aSrc1: assert property (@(posedge clk) dataOn |-> src1Data_o == expSrc1)
    else begin
      errCount++;
      $error("Mismatch src1Data_o: got %h expected %h", $sampled(src1Data_o),
             $sampled(expSrc1));
    end

  aSrc2: assert property (@(posedge clk) dataOn |-> src2Data_o == expSrc2)
    else begin
      errCount++;
      $error("Mismatch src2Data_o: got %h expected %h", $sampled(src2Data_o),
             $sampled(expSrc2));
    end

  aReady: assert property (@(posedge clk) started |-> phyRegRdy_o == expReady)
    else begin
      errCount++;
      $error("Mismatch phyRegRdy_o: got %h expected %h", $sampled(phyRegRdy_o),
             $sampled(expReady));
    end

  aIdleAfterReset: assert property (@(posedge clk) rst_i |=> laneValid_o == '0)
    else begin
      errCount++;
      $error("laneValid_o was not cleared by reset");
    end

  aReadyInit: assert property (@(posedge clk)
      (rst_i || exception_i) |=> phyRegRdy_o == archReady())
    else begin
      errCount++;
      $error("phyRegRdy_o did not return to the architectural pattern");
    end

endmodule

bind regReadStage regReadStage_chk chk (.*);

`default_nettype wire

// ==== test/regReadStage_tb.sv ====
// **************************************************
// Testbench for the register-read stage. Random stimulus
// comes from an LFSR and the bound checker does the checking.
// **************************************************

`timescale 1ns/1ps
`default_nettype none

module regReadStage_tb;

  import rrConfigPkg::*;
  import rrTypesPkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int RESET_CYCLES = 4;
  localparam int NUM_CYCLES = 600;
  localparam int WATCHDOG_NS = (RESET_CYCLES + NUM_CYCLES + 50) * CLK_PERIOD * 2;

  logic clk;
  logic rst_i;
  logic [NUM_LANES-1:0] laneValid_i;
  physTag_t [NUM_LANES-1:0] src1Tag_i;
  physTag_t [NUM_LANES-1:0] src2Tag_i;
  branchMask_t [NUM_LANES-1:0] branchMask_i;
  alId_t [NUM_LANES-1:0] alId_i;
  logic [NUM_LANES-1:0] bypassValid_i;
  physTag_t [NUM_LANES-1:0] bypassDest_i;
  regData_t [NUM_LANES-1:0] bypassData_i;
  logic [NUM_LANES-1:0] unmapValid_i;
  physTag_t [NUM_LANES-1:0] unmapTag_i;
  logic [NUM_LANES-1:0] wakeupValid_i;
  physTag_t [NUM_LANES-1:0] wakeupTag_i;
  logic ctrlVerified_i;
  logic ctrlMispredict_i;
  ckptId_t ctrlCkptId_i;
  logic recover_i;
  logic exception_i;
  logic [NUM_LANES-1:0] laneValid_o;
  regData_t [NUM_LANES-1:0] src1Data_o;
  regData_t [NUM_LANES-1:0] src2Data_o;
  alId_t [NUM_LANES-1:0] alId_o;
  readyVec_t phyRegRdy_o;

  logic [31:0] lfsrState;

  regReadStage DUT (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Taps 32, 22, 2 and 1 give a maximal-length sequence.
  function automatic logic [31:0] nextLfsr(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  function automatic logic [31:0] takeBits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsrState = nextLfsr(lfsrState);
      value = {value[30:0], lfsrState[0]};
    end
    return value;
  endfunction

  // True with a chance of one in two to the power of bitCount.
  function automatic logic allBitsSet(input int bitCount);
    logic [31:0] bits;
    bits = takeBits(bitCount);
    return bits == ((32'd1 << bitCount) - 32'd1);
  endfunction

  function automatic physTag_t randomTag();
    logic [31:0] bits;
    bits = takeBits(3);
    if (bits[2:0] != 3'd0) begin
      bits = takeBits(3);  // A small pool of tags makes bypass hits common.
    end else begin
      bits = takeBits(PHYS_TAG_W);
    end
    return bits[PHYS_TAG_W-1:0];
  endfunction

  task automatic clearInputs();
    laneValid_i <= '0;
    src1Tag_i <= '0;
    src2Tag_i <= '0;
    branchMask_i <= '0;
    alId_i <= '0;
    bypassValid_i <= '0;
    bypassDest_i <= '0;
    bypassData_i <= '0;
    unmapValid_i <= '0;
    unmapTag_i <= '0;
    wakeupValid_i <= '0;
    wakeupTag_i <= '0;
    ctrlVerified_i <= 1'b0;
    ctrlMispredict_i <= 1'b0;
    ctrlCkptId_i <= '0;
    recover_i <= 1'b0;
    exception_i <= 1'b0;
  endtask

  task automatic driveRandomCycle();
    logic [31:0] bits;
    for (int l = 0; l < NUM_LANES; l++) begin
      laneValid_i[l] <= !allBitsSet(2);
      src1Tag_i[l] <= randomTag();
      src2Tag_i[l] <= randomTag();
      bits = takeBits(NUM_CHECKPOINTS);
      branchMask_i[l] <= bits[NUM_CHECKPOINTS-1:0];
      bits = takeBits(AL_ID_W);
      alId_i[l] <= bits[AL_ID_W-1:0];
      bypassValid_i[l] <= allBitsSet(1);
      bypassDest_i[l] <= randomTag();
      bypassData_i[l] <= takeBits(DATA_W);
      unmapValid_i[l] <= allBitsSet(2);
      unmapTag_i[l] <= randomTag();
      wakeupValid_i[l] <= allBitsSet(2);
      wakeupTag_i[l] <= randomTag();
    end
    ctrlVerified_i <= allBitsSet(1);
    ctrlMispredict_i <= allBitsSet(1);
    bits = takeBits(CKPT_ID_W);
    ctrlCkptId_i <= bits[CKPT_ID_W-1:0];
    recover_i <= allBitsSet(3);
    exception_i <= allBitsSet(5);
  endtask

  initial begin
    lfsrState = 32'h0e27_c460;
    rst_i <= 1'b1;
    clearInputs();
    repeat (RESET_CYCLES) @(posedge clk);
    rst_i <= 1'b0;
    for (int c = 0; c < NUM_CYCLES; c++) begin
      @(posedge clk);
      driveRandomCycle();
    end
    @(posedge clk);
    clearInputs();
    repeat (3) @(posedge clk);
    @(negedge clk);
    if (DUT.chk.errCount == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("ERRORS FOUND");
      $fatal(1, "A checker assertion failed");
    end
  end

  // Stop at the first assertion failure.
  always @(negedge clk) begin
    if (DUT.chk.errCount != 0) begin
      $display("ERRORS FOUND");
      $fatal(1, "A checker assertion failed");
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("ERRORS FOUND");
    $fatal(1, "Timeout: the stimulus did not complete in time");
  end

endmodule

`default_nettype wire
